//--- vlog.f
logic/isaPkg.sv
logic/controlPkg.sv
logic/cycleSequencer.sv
logic/statusFlags.sv
logic/controlDecode.sv
logic/control.sv
bench/controlTb.sv

//--- run.sh
#!/bin/bash
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module controlTb -o controlSim

# The log decides the result, so a stopped simulation must not end the script here
./obj_dir/controlSim > sim.log 2>&1 || true
cat sim.log

grep -qxF '** PASS **' sim.log

//--- bench/controlTb.sv
// Testbench for the processor control unit checking fetch, execute, flags, branches and memory timing
`timescale 1ns/1ns

module controlTb import isaPkg::*, controlPkg::*; ();

	localparam int period = 40;
	localparam int resetCycles = 8;
	localparam int numInstr = 24;
	localparam int maxStall = 2;	// Per wait phase
	// Two wait phases at most per instruction
	localparam int timeoutNs = 2 * (numInstr * 9 + numInstr * 2 * maxStall) * period;

	localparam logic [7:0] instrList [numInstr] = '{
		{ADD, 3'd0}, {CMP, 3'd0}, {BRANCH, BE}, {BRANCH, BNE},
		{ADDI, 3'd0}, {LUI, 3'd0}, {BRANCH, BLT}, {BRANCH, BGE},
		{SUB, 3'd0}, {LDW, 3'd0}, {BRANCH, BR}, {XOR, 3'd0},
		{STW, 3'd0}, {BRANCH, JMP}, {CMPI, 3'd0}, {LLI, 3'd0},
		{BRANCH, BWL}, {BRANCH, RET}, {ADDIB, 3'd0}, {BRANCH, BE},
		{NEG, 3'd0}, {BRANCH, BNE}, {NOR, 3'd0}, {LDW, 3'd0}
	};

	logic Clock, nReset, nWait;
	logic [3:0] Flags;
	logic [7:0] OpcodeCondIn;
	logic ALE, AluEn, AluWe, CFlag, ENB, IrWe, LrEn, LrWe, MemEn;
	logic nME, nOE, nWE, PcEn, PcWe, RegWe;
	pcSel_t PcSel;
	op1Sel_t Op1Sel;
	op2Sel_t Op2Sel;
	immSel_t ImmSel;
	lrSel_t LrSel;
	rs1Sel_t Rs1Sel;
	wdSel_t WdSel;

	integer seed;
	logic [3:0] status;	// Flags from the last ALU opcode
	logic expAle, expIrWe, expNme, expNwe, expRegWe, expLrWe, expLrEn, expPcWe, expCFlag;
	logic execChk, chkOp2, chkRs1Rd;
	pcSel_t expPcSel;
	wdSel_t expWdSel;

	control i_control (.*);

	initial begin
		Clock = 1'b0;
		forever #(period / 2) Clock = ~Clock;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string sigName, input logic [3:0] expected,
			input logic [3:0] actual);
		failRun($sformatf("ERR %0t %s expected %0h actual %0h", $time, sigName, expected, actual));
	endtask

	assert property (@(posedge Clock) !nReset |-> ALE && nME && !RegWe && !PcWe && !IrWe)
		else failRun("Outputs not idle while reset is asserted");
	assert property (@(posedge Clock) disable iff (!nReset) ALE == expAle)
		else reportMismatch("ALE", 4'($sampled(expAle)), 4'($sampled(ALE)));
	assert property (@(posedge Clock) disable iff (!nReset) IrWe == expIrWe)
		else reportMismatch("IrWe", 4'($sampled(expIrWe)), 4'($sampled(IrWe)));
	assert property (@(posedge Clock) disable iff (!nReset) nME == expNme)
		else reportMismatch("nME", 4'($sampled(expNme)), 4'($sampled(nME)));
	assert property (@(posedge Clock) disable iff (!nReset) nWE == expNwe)
		else reportMismatch("nWE", 4'($sampled(expNwe)), 4'($sampled(nWE)));
	assert property (@(posedge Clock) disable iff (!nReset) RegWe == expRegWe)
		else reportMismatch("RegWe", 4'($sampled(expRegWe)), 4'($sampled(RegWe)));
	assert property (@(posedge Clock) disable iff (!nReset) LrWe == expLrWe)
		else reportMismatch("LrWe", 4'($sampled(expLrWe)), 4'($sampled(LrWe)));
	assert property (@(posedge Clock) disable iff (!nReset) LrEn == expLrEn)
		else reportMismatch("LrEn", 4'($sampled(expLrEn)), 4'($sampled(LrEn)));
	assert property (@(posedge Clock) disable iff (!nReset) CFlag == expCFlag)
		else reportMismatch("CFlag", 4'($sampled(expCFlag)), 4'($sampled(CFlag)));
	assert property (@(posedge Clock) disable iff (!nReset) execChk |-> PcSel == expPcSel)
		else reportMismatch("PcSel", 4'($sampled(expPcSel)), 4'($sampled(PcSel)));
	assert property (@(posedge Clock) disable iff (!nReset) execChk |-> PcWe == expPcWe)
		else reportMismatch("PcWe", 4'($sampled(expPcWe)), 4'($sampled(PcWe)));
	assert property (@(posedge Clock) disable iff (!nReset) chkOp2 |-> Op2Sel == Op2Rd2)
		else reportMismatch("Op2Sel", 4'(Op2Rd2), 4'($sampled(Op2Sel)));
	assert property (@(posedge Clock) disable iff (!nReset) chkRs1Rd |-> Rs1Sel == Rs1Rd)
		else reportMismatch("Rs1Sel", 4'(Rs1Rd), 4'($sampled(Rs1Sel)));
	assert property (@(posedge Clock) disable iff (!nReset) expLrWe |-> LrSel == LrPc)
		else reportMismatch("LrSel", 4'(LrPc), 4'($sampled(LrSel)));
	assert property (@(posedge Clock) disable iff (!nReset) expRegWe |-> WdSel == expWdSel)
		else reportMismatch("WdSel", 4'($sampled(expWdSel)), 4'($sampled(WdSel)));

	// Branch rule on the stored Z, N and V
	function automatic logic conditionHolds(input branch_t br, input logic [3:0] st);
		case (br)
			BR, BWL: return 1'b1;
			BNE: return !st[flagZ];
			BE: return st[flagZ];
			BLT: return st[flagN] != st[flagV];
			BGE: return st[flagN] == st[flagV];
			default: return 1'b0;
		endcase
	endfunction

	task automatic clearExpect();
		expAle = 1'b0;
		expIrWe = 1'b0;
		expNme = 1'b1;
		expNwe = 1'b1;
		expRegWe = 1'b0;
		expLrWe = 1'b0;
		expLrEn = 1'b0;
		expPcWe = 1'b0;
		execChk = 1'b0;
		chkOp2 = 1'b0;
		chkRs1Rd = 1'b0;
		expPcSel = Pc1;
		expWdSel = WdAlu;
		expCFlag = status[flagC];
	endtask

	// Fresh random Flags and nWait in every cycle
	task automatic nextCycle();
		logic [31:0] rnd;
		@(posedge Clock);
		#5;
		rnd = $random(seed);
		Flags = rnd[3:0];
		nWait = rnd[4];
		clearExpect();
	endtask

	task automatic holdCycle2(input logic irWe, input logic regWe);
		int stalls;
		stalls = {$random(seed)} % (maxStall + 1);
		for (int k = 0; k <= stalls; k++) begin
			nWait = (k == stalls);	// Low nWait adds a cycle
			expNme = 1'b0;
			expIrWe = irWe;
			expRegWe = regWe;
			if (regWe)
				expWdSel = WdSys;
			nextCycle();
		end
	endtask

	task automatic runInstr(input logic [7:0] instr);
		opcode_t op;
		branch_t br;
		op = opcode_t'(instr[7:3]);
		br = branch_t'(instr[2:0]);
		OpcodeCondIn = instr;
		expAle = 1'b1;	// Fetch cycle0
		nextCycle();
		expNme = 1'b0;
		nextCycle();
		holdCycle2(1'b1, 1'b0);
		nextCycle();	// Fetch cycle3 has nothing to check
		execChk = 1'b1;
		expPcWe = !(op inside {LDW, STW});
		if (op <= NEG) begin
			expRegWe = !(op inside {CMP, CMPI});
			chkOp2 = op inside {ADD, SUB, CMP, AND, OR, XOR, NAND, NOR};
			chkRs1Rd = op inside {ADDIB, SUBIB};
			status = Flags;	// Loaded at the end of this cycle
		end else if (op inside {LUI, LLI}) begin
			expRegWe = 1'b1;
		end else if (op == BRANCH) begin
			expLrWe = (br == BWL);
			expLrEn = (br == RET);
			if (br == RET)
				expPcSel = PcSysbus;
			else if (br == JMP || conditionHolds(br, status))
				expPcSel = PcAluOut;
		end
		nextCycle();
		if (op inside {LDW, STW}) begin
			expAle = 1'b1;	// Address phase again
			nextCycle();
			expNme = 1'b0;
			nextCycle();
			holdCycle2(1'b0, op == LDW);
			expNwe = (op != STW);
			nextCycle();
		end
	endtask

	initial begin
		#(timeoutNs + resetCycles * period);
		failRun("Timeout, the instruction sequence did not complete in time");
	end

	initial begin
		seed = 32'h176e_be73;
		nReset = 1'b0;
		nWait = 1'b1;
		Flags = 4'h0;
		OpcodeCondIn = 8'h00;
		status = 4'h0;
		clearExpect();
		repeat (resetCycles) nextCycle();
		nReset = 1'b1;	// DUT sits in fetch cycle0 now
		for (int i = 0; i < numInstr; i++)
			runInstr(instrList[i]);
		$display("** PASS **");
		$finish;
	end

endmodule

//--- logic/control.sv
// Processor control unit top level splitting the opcode byte and joining sequencer, flags and decode
`timescale 1ns/1ns

module control import isaPkg::*, controlPkg::*; (
	input  logic                             Clock,
	input  logic                             nReset,
	input  logic [flagWidth-1:0]             Flags,
	input  logic                             nWait,
	input  logic [opcodeWidth+branchWidth-1:0] OpcodeCondIn,
	output logic                             ALE,
	output logic                             AluEn,
	output logic                             AluWe,
	output logic                             CFlag,
	output logic                             ENB,
	output logic                             IrWe,
	output logic                             LrEn,
	output logic                             LrWe,
	output logic                             MemEn,
	output logic                             nME,
	output logic                             nOE,
	output logic                             nWE,
	output logic                             PcEn,
	output logic                             PcWe,
	output logic                             RegWe,
	output pcSel_t                           PcSel,
	output op1Sel_t                          Op1Sel,
	output op2Sel_t                          Op2Sel,
	output immSel_t                          ImmSel,
	output lrSel_t                           LrSel,
	output rs1Sel_t                          Rs1Sel,
	output wdSel_t                           WdSel
);

	opcode_t opcode;
	branch_t branchCode;
	logic memAccess;
	logic branchTaken;
	logic statusWe;
	state_t state;
	stateSub_t stateSub;

	// Opcode in upper bits, condition below
	assign opcode = opcode_t'(OpcodeCondIn[opcodeWidth+branchWidth-1:branchWidth]);
	assign branchCode = branch_t'(OpcodeCondIn[branchWidth-1:0]);
	assign memAccess = (opcode == LDW) || (opcode == STW);

	cycleSequencer i_cycleSequencer (.Clock, .nReset, .nWait, .memAccess, .state, .stateSub);

	statusFlags i_statusFlags (.Clock, .nReset, .statusWe, .Flags, .branchCode, .branchTaken, .CFlag);

	controlDecode i_controlDecode (
		.state, .stateSub, .opcode, .branchCode, .branchTaken,
		.ALE, .AluEn, .AluWe, .ENB, .IrWe, .LrEn, .LrWe, .MemEn,
		.nME, .nOE, .nWE, .PcEn, .PcWe, .RegWe, .statusWe,
		.PcSel, .Op1Sel, .Op2Sel, .ImmSel, .LrSel, .Rs1Sel, .WdSel
	);

endmodule

//--- logic/controlDecode.sv
// Control decode from machine phase and opcode to datapath and memory control lines
`timescale 1ns/1ns

module controlDecode import isaPkg::*, controlPkg::*; (
	input  state_t    state,
	input  stateSub_t stateSub,
	input  opcode_t   opcode,
	input  branch_t   branchCode,
	input  logic      branchTaken,
	output logic      ALE,
	output logic      AluEn,
	output logic      AluWe,
	output logic      ENB,
	output logic      IrWe,
	output logic      LrEn,
	output logic      LrWe,
	output logic      MemEn,
	output logic      nME,
	output logic      nOE,
	output logic      nWE,
	output logic      PcEn,
	output logic      PcWe,
	output logic      RegWe,
	output logic      statusWe,
	output pcSel_t    PcSel,
	output op1Sel_t   Op1Sel,
	output op2Sel_t   Op2Sel,
	output immSel_t   ImmSel,
	output lrSel_t    LrSel,
	output rs1Sel_t   Rs1Sel,
	output wdSel_t    WdSel
);

	always_comb begin
		ALE = 1'b0;
		AluEn = 1'b0;
		AluWe = 1'b0;
		ENB = 1'b0;
		IrWe = 1'b0;
		LrEn = 1'b0;
		LrWe = 1'b0;
		MemEn = 1'b0;
		nME = 1'b1;
		nOE = 1'b1;
		nWE = 1'b1;
		PcEn = 1'b0;
		PcWe = 1'b0;
		RegWe = 1'b0;
		statusWe = 1'b0;
		PcSel = Pc1;
		Op1Sel = Op1Rd1;
		Op2Sel = Op2Imm;
		ImmSel = ImmLong;
		LrSel = LrSys;
		Rs1Sel = Rs1Ra;
		WdSel = WdAlu;
		if (state == fetch) begin
			case (stateSub)
				cycle0: begin
					ALE = 1'b1;	// PC out as address
					PcEn = 1'b1;
				end
				cycle1: begin
					nME = 1'b0;
					MemEn = 1'b1;
					PcEn = 1'b1;
				end
				cycle2: begin
					nME = 1'b0;
					nOE = 1'b0;
					MemEn = 1'b1;
					ENB = 1'b1;
					IrWe = 1'b1;
				end
				cycle3: begin
					nOE = 1'b0;
					MemEn = 1'b1;
					ENB = 1'b1;
				end
				default: ;
			endcase
		end else if (stateSub == cycle4) begin
			case (opcode)
				ADD, SUB, CMP, AND, OR, XOR, NAND, NOR,
				ADDI, SUBI, CMPI, LSL, LSR, ASR,
				ADDIB, SUBIB, ADC, ADCI, SUC, SUCI, NOT, NEG: begin
					PcEn = 1'b1;
					PcWe = 1'b1;
					statusWe = 1'b1;
					RegWe = (opcode != CMP) && (opcode != CMPI);	// Compare only sets flags
					if (opcode inside {ADD, SUB, CMP, AND, OR, XOR, NAND, NOR})
						Op2Sel = Op2Rd2;
					if (opcode inside {ADDI, SUBI, CMPI, LSL, LSR, ASR})
						ImmSel = ImmShort;
					if (opcode inside {ADDIB, SUBIB})
						Rs1Sel = Rs1Rd;	// Byte immediate reads through Rd
				end
				LUI, LLI: begin
					AluEn = 1'b1;
					RegWe = 1'b1;
					PcWe = 1'b1;
					Rs1Sel = Rs1Rd;
				end
				LDW, STW: begin
					AluEn = 1'b1;	// Address sum
					AluWe = 1'b1;
					ImmSel = ImmShort;
				end
				BRANCH:
					case (branchCode)
						RET: begin
							LrEn = 1'b1;
							PcWe = 1'b1;
							PcSel = PcSysbus;
						end
						JMP: begin
							ImmSel = ImmShort;
							PcWe = 1'b1;
							PcSel = PcAluOut;
						end
						default: begin
							AluEn = 1'b1;
							PcWe = 1'b1;
							Op1Sel = Op1Pc;	// PC relative target
							if (branchTaken) begin
								PcSel = PcAluOut;
								if (branchCode == BWL) begin
									LrWe = 1'b1;
									LrSel = LrPc;
								end
							end
						end
					endcase
				default: begin
					PcEn = 1'b1;	// Unused code skips ahead
					PcWe = 1'b1;
				end
			endcase
		end else begin
			// Memory cycles of LDW and STW
			case (stateSub)
				cycle0: begin
					ALE = 1'b1;
					AluEn = 1'b1;
					ImmSel = ImmShort;
				end
				cycle1: begin
					nME = 1'b0;
					AluEn = 1'b1;
					AluWe = 1'b1;
					Op2Sel = Op2zero;
					Rs1Sel = Rs1Rd;
					MemEn = (opcode == LDW);
				end
				cycle2: begin
					nME = 1'b0;
					if (opcode == LDW) begin
						nOE = 1'b0;
						MemEn = 1'b1;
						ENB = 1'b1;
						RegWe = 1'b1;
						WdSel = WdSys;
					end else begin
						AluEn = 1'b1;	// Store data onto bus
						Op2Sel = Op2zero;
					end
				end
				cycle3: begin
					PcWe = 1'b1;	// Access complete, step PC once
					if (opcode == LDW) begin
						nOE = 1'b0;
						MemEn = 1'b1;
					end else begin
						nWE = 1'b0;
						AluEn = 1'b1;
						Op2Sel = Op2zero;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

//--- logic/statusFlags.sv
// Status flag register with branch condition evaluation
`timescale 1ns/1ns

module statusFlags import isaPkg::*, controlPkg::*; (
	input  logic                 Clock,
	input  logic                 nReset,
	input  logic                 statusWe,
	input  logic [flagWidth-1:0] Flags,
	input  branch_t              branchCode,
	output logic                 branchTaken,
	output logic                 CFlag
);

	logic [flagWidth-1:0] status;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			status <= '0;
		else if (statusWe)
			status <= Flags;	// Loaded from ALU
	end

	assign CFlag = status[flagC];

	// Uses flags left by the previous ALU op
	always_comb begin
		case (branchCode)
			BR, BWL: branchTaken = 1'b1;
			BNE:     branchTaken = ~status[flagZ];
			BE:      branchTaken = status[flagZ];
			BLT:     branchTaken = status[flagN] ^ status[flagV];
			BGE:     branchTaken = ~(status[flagN] ^ status[flagV]);
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

//--- logic/cycleSequencer.sv
// Cycle sequencer stepping fetch and execute sub-cycles with memory wait states
`timescale 1ns/1ns

module cycleSequencer import controlPkg::*; (
	input  logic      Clock,
	input  logic      nReset,
	input  logic      nWait,
	input  logic      memAccess,
	output state_t    state,
	output stateSub_t stateSub
);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			state <= fetch;
			stateSub <= cycle0;
		end else begin
			case (state)
				fetch:
					case (stateSub)
						cycle0: stateSub <= cycle1;
						cycle1: stateSub <= cycle2;
						cycle2: if (nWait) stateSub <= cycle3;	// Hold for slow memory
						cycle3: begin
							state <= execute;
							stateSub <= cycle4;
						end
						default: stateSub <= cycle0;
					endcase
				execute:
					case (stateSub)
						cycle4: begin
							// Only loads and stores need the bus again
							if (!memAccess)
								state <= fetch;
							stateSub <= cycle0;
						end
						cycle0: stateSub <= cycle1;
						cycle1: stateSub <= cycle2;
						cycle2: if (nWait) stateSub <= cycle3;
						cycle3: begin
							state <= fetch;
							stateSub <= cycle0;
						end
						default: begin
							state <= fetch;
							stateSub <= cycle0;
						end
					endcase
				default: begin
					state <= fetch;
					stateSub <= cycle0;
				end
			endcase
		end
	end

endmodule

//--- logic/controlPkg.sv
// Machine timing definitions: major state, sub-cycle and status flag positions
package controlPkg;

	typedef enum logic {
		fetch,
		execute
	} state_t;

	// Fetch uses cycle0..3, execute starts in cycle4
	typedef enum logic [2:0] {
		cycle0,
		cycle1,
		cycle2,
		cycle3,
		cycle4
	} stateSub_t;

	// Status register bit positions
	localparam int flagZ = 0;
	localparam int flagC = 1;
	localparam int flagV = 2;
	localparam int flagN = 3;

endpackage

//--- logic/isaPkg.sv
// Instruction set definitions: opcodes, branch codes, datapath selects and field widths
package isaPkg;

	localparam int opcodeWidth = 5;
	localparam int branchWidth = 3;
	localparam int flagWidth = 4;

	// Unused codes above BRANCH decode as no-ops
	typedef enum logic [opcodeWidth-1:0] {
		ADD,
		ADDI,
		ADDIB,
		ADC,
		ADCI,
		SUB,
		SUBI,
		SUBIB,
		SUC,
		SUCI,
		CMP,
		CMPI,
		AND,
		OR,
		XOR,
		NOT,
		NAND,
		NOR,
		LSL,
		LSR,
		ASR,
		NEG,
		LUI,
		LLI,
		LDW,	// Five cycle memory ops
		STW,
		BRANCH	// Condition in low three bits
	} opcode_t;

	typedef enum logic [branchWidth-1:0] {
		BR  = 3'd0,
		JMP = 3'd1,
		RET = 3'd2,
		BWL = 3'd3,
		BNE = 3'd4,
		BE  = 3'd5,
		BLT = 3'd6,
		BGE = 3'd7
	} branch_t;

	// Datapath multiplexer selects
	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSel_t;
	typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2zero} op2Sel_t;
	typedef enum logic {ImmLong, ImmShort} immSel_t;
	typedef enum logic {LrSys, LrPc} lrSel_t;
	typedef enum logic {Rs1Ra, Rs1Rd} rs1Sel_t;
	typedef enum logic {WdAlu, WdSys} wdSel_t;

endpackage
